//--- hw/audio_pkg.sv
package audio_pkg;

	// ------------------------------
	// Sample and control types
	// ------------------------------

	// One signed PCM sample from the sound card
	typedef logic signed [15:0] sample_t;

	// Speaker volume step, 0 is the quietest
	typedef logic [1:0] spk_level_t;

	// Compressor mode, shared by all channels
	typedef enum logic [1:0] {
		BOOST_NONE = 2'd0,
		BOOST_2X   = 2'd1,
		BOOST_4X   = 2'd2
	} boost_e;

	// Raw and compressed versions of the same sample, kept in step
	typedef struct packed {
		sample_t raw;
		sample_t shaped;
	} comp_lane_t;

	// ------------------------------
	// Speaker scaling
	// ------------------------------

	// Speaker bit lands at bit 11..14 depending on the volume step
	localparam int unsigned SPK_BASE_SHIFT = 11;

	// ------------------------------
	// Compressor curves
	// ------------------------------

	// Below the knee the magnitude is multiplied by GAIN,
	// above it the slope drops to 1/FACTOR starting from BASE
	localparam logic [15:0] CMP2_FACTOR = 16'd4;
	localparam logic [15:0] CMP2_GAIN   = 16'd2;
	localparam logic [15:0] CMP2_KNEE   = 16'd14044;
	localparam logic [15:0] CMP2_BASE   = 16'd28088;

	localparam logic [15:0] CMP4_FACTOR = 16'd8;
	localparam logic [15:0] CMP4_GAIN   = 16'd4;
	localparam logic [15:0] CMP4_KNEE   = 16'd7399;
	localparam logic [15:0] CMP4_BASE   = 16'd29596;

endpackage

//--- hw/speaker_mixer.sv
`timescale 1ns/1ps

module speaker_mixer
	import audio_pkg::*;
#(
	parameter int N_CH = 2
) (
	input  logic                  clk_sys,
	input  logic                  cpu_reset,

	input  sample_t [N_CH-1:0]    sb_sample,
	input  logic                  speaker_out,
	input  spk_level_t            spk_level,
	input  logic [1:0]            boost_sel,

	output sample_t [N_CH-1:0]    mixed,
	output boost_e                boost
);

	// ------------------------------
	// Speaker term
	// ------------------------------

	// Registered one cycle ahead of the sum
	sample_t spk_term;

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			spk_term <= '0;
		end else if (speaker_out) begin
			spk_term <= sample_t'(16'd1 << (SPK_BASE_SHIFT + 32'(spk_level)));
		end else begin
			spk_term <= '0;
		end
	end

	// ------------------------------
	// Boost decode
	// ------------------------------

	boost_e boost_dec;

	// Both upper codes select the 4x curve
	always_comb begin
		case (boost_sel)
			2'd0:    boost_dec = BOOST_NONE;
			2'd1:    boost_dec = BOOST_2X;
			default: boost_dec = BOOST_4X;
		endcase
	end

	// ------------------------------
	// Channel sums
	// ------------------------------

	// Plain 16-bit wraparound, a loud sample plus the speaker may flip sign
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			mixed <= '0;
			boost <= BOOST_NONE;
		end else begin
			for (int ch = 0; ch < N_CH; ch++) begin
				mixed[ch] <= sb_sample[ch] + spk_term;
			end
			// Boost travels with the sample it arrived alongside
			boost <= boost_dec;
		end
	end

endmodule

//--- hw/sample_compressor.sv
`timescale 1ns/1ps

module sample_compressor
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        cpu_reset,

	input  sample_t     mixed,
	input  boost_e      boost,

	output comp_lane_t  lane,
	output boost_e      boost_q
);

	// ------------------------------
	// Magnitude
	// ------------------------------

	logic [15:0] mag;

	always_comb begin
		mag = mixed[15] ? (~mixed + 16'd1) : mixed;
	end

	// ------------------------------
	// Two-slope curves
	// ------------------------------

	logic [15:0] mag_2x;
	logic [15:0] mag_4x;
	logic [15:0] mag_sel;
	sample_t     shaped;

	// Steep slope below the knee, shallow slope above it
	always_comb begin
		if (mag < CMP2_KNEE) begin
			mag_2x = mag * CMP2_GAIN;
		end else begin
			mag_2x = ((mag - CMP2_KNEE) / CMP2_FACTOR) + CMP2_BASE;
		end
	end

	always_comb begin
		if (mag < CMP4_KNEE) begin
			mag_4x = mag * CMP4_GAIN;
		end else begin
			mag_4x = ((mag - CMP4_KNEE) / CMP4_FACTOR) + CMP4_BASE;
		end
	end

	// Only the 4x mode picks the second curve
	always_comb begin
		mag_sel = (boost == BOOST_4X) ? mag_4x : mag_2x;
	end

	// Restore the sign
	always_comb begin
		shaped = mixed[15] ? sample_t'(~(mag_sel - 16'd1)) : sample_t'(mag_sel);
	end

	// ------------------------------
	// Lane register
	// ------------------------------

	// Raw is held back with the shaped value so both describe one sample
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			lane    <= '0;
			boost_q <= BOOST_NONE;
		end else begin
			lane.raw    <= mixed;
			lane.shaped <= shaped;
			boost_q     <= boost;
		end
	end

	// The curve never flips the sign, apart from the 2x wrap to 8000 at full scale
	a_sign_kept: assert property (
		@(posedge clk_sys) disable iff (cpu_reset)
		(lane.raw != '0 && lane.raw != sample_t'(16'h8000) &&
			lane.shaped != sample_t'(16'h8000))
		|-> (lane.shaped[15] == lane.raw[15])
	);

endmodule

//--- hw/audio_out_stage.sv
`timescale 1ns/1ps

module audio_out_stage
	import audio_pkg::*;
#(
	parameter int N_CH = 2
) (
	input  logic                   clk_sys,
	input  logic                   cpu_reset,

	input  comp_lane_t [N_CH-1:0]  lanes,
	input  boost_e                 boost,

	output sample_t [N_CH-1:0]     audio_out
);

	// ------------------------------
	// Output select and register
	// ------------------------------

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			audio_out <= '0;
		end else begin
			for (int ch = 0; ch < N_CH; ch++) begin
				// Boost is the copy that rode along with this very sample
				if (boost == BOOST_NONE) begin
					audio_out[ch] <= lanes[ch].raw;
				end else begin
					audio_out[ch] <= lanes[ch].shaped;
				end
			end
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------

	// With boost off the mixed sample must pass through untouched
	for (genvar ch = 0; ch < N_CH; ch++) begin : g_chk
		a_bypass: assert property (
			@(posedge clk_sys) disable iff (cpu_reset)
			(boost == BOOST_NONE) |=> (audio_out[ch] == $past(lanes[ch].raw))
		);
	end

endmodule

//--- hw/audio_output_path.sv
`timescale 1ns/1ps

module audio_output_path
	import audio_pkg::*;
#(
	parameter int N_CH = 2
) (
	input  logic                  clk_sys,
	input  logic                  cpu_reset,

	input  sample_t [N_CH-1:0]    sb_sample,
	input  logic                  speaker_out,
	input  spk_level_t            spk_level,
	input  logic [1:0]            boost_sel,

	output sample_t [N_CH-1:0]    audio_out
);

	// ------------------------------
	// Interconnect
	// ------------------------------

	sample_t    [N_CH-1:0] mixed;
	boost_e                boost;

	comp_lane_t [N_CH-1:0] lanes;
	boost_e     [N_CH-1:0] lane_boost;

	// ------------------------------
	// Mixer
	// ------------------------------

	speaker_mixer #(
		.N_CH(N_CH)
	) speaker_mixer_inst (
		.clk_sys    (clk_sys),
		.cpu_reset  (cpu_reset),
		.sb_sample  (sb_sample),
		.speaker_out(speaker_out),
		.spk_level  (spk_level),
		.boost_sel  (boost_sel),
		.mixed      (mixed),
		.boost      (boost)
	);

	// ------------------------------
	// Per-channel compressors
	// ------------------------------

	for (genvar ch = 0; ch < N_CH; ch++) begin : g_lane
		sample_compressor sample_compressor_inst (
			.clk_sys  (clk_sys),
			.cpu_reset(cpu_reset),
			.mixed    (mixed[ch]),
			.boost    (boost),
			.lane     (lanes[ch]),
			.boost_q  (lane_boost[ch])
		);
	end

	// ------------------------------
	// Output stage
	// ------------------------------

	// All lanes carry the same boost, lane 0 speaks for them
	audio_out_stage #(
		.N_CH(N_CH)
	) audio_out_stage_inst (
		.clk_sys  (clk_sys),
		.cpu_reset(cpu_reset),
		.lanes    (lanes),
		.boost    (lane_boost[0]),
		.audio_out(audio_out)
	);

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_sys,
	output logic cpu_reset
);

	// Free running clock, first rising edge at half a period
	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Reset is seen high on the first RESET_CYCLES rising edges
	initial begin
		cpu_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		cpu_reset <= 1'b0;
	end

endmodule

//--- verif/tb_audio_output_path.sv
`timescale 1ns/1ps

module tb_audio_output_path
	import audio_pkg::*;
();

	localparam int N_CH       = 2;
	localparam int CLK_PERIOD = 20;
	localparam int SEED       = 32'h6a9a;

	// Phase lengths in clock cycles
	localparam int N_RESET  = 10;
	localparam int N_PASS   = 150;
	localparam int N_SPK    = 150;
	localparam int N_2X     = 200;
	localparam int N_4X     = 200;
	localparam int N_SWITCH = 300;
	localparam int N_DRAIN  = 6;

	localparam int TOTAL_CYCLES = N_RESET + N_PASS + N_SPK + N_2X + N_4X + N_SWITCH + N_DRAIN;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

	// Reference curve points
	localparam int SPK_SHIFT = 11;
	localparam int KNEE_2X   = 14044;
	localparam int BASE_2X   = 28088;
	localparam int FACTOR_2X = 4;
	localparam int GAIN_2X   = 2;
	localparam int KNEE_4X   = 7399;
	localparam int BASE_4X   = 29596;
	localparam int FACTOR_4X = 8;
	localparam int GAIN_4X   = 4;

	logic               clk_sys;
	logic               cpu_reset;
	sample_t [N_CH-1:0] sb_sample;
	logic               speaker_out;
	spk_level_t         spk_level;
	logic [1:0]         boost_sel;
	sample_t [N_CH-1:0] audio_out;

	// Inputs as the DUT sees them on one rising edge
	typedef struct packed {
		logic               rst;
		sample_t [N_CH-1:0] smp;
		logic               spk;
		spk_level_t         lvl;
		logic [1:0]         bsel;
	} in_rec_t;

	// Entry 0 holds the edge just taken and entry 3 the one three edges back
	in_rec_t hist [4];
	int      cycle_no;

	tb_clock_gen #(
		.PERIOD_NS   (CLK_PERIOD),
		.RESET_CYCLES(5)
	) tb_clock_gen_inst (
		.clk_sys  (clk_sys),
		.cpu_reset(cpu_reset)
	);

	audio_output_path #(
		.N_CH(N_CH)
	) audio_output_path_inst (
		.clk_sys    (clk_sys),
		.cpu_reset  (cpu_reset),
		.sb_sample  (sb_sample),
		.speaker_out(speaker_out),
		.spk_level  (spk_level),
		.boost_sel  (boost_sel),
		.audio_out  (audio_out)
	);

	// ------------------------------
	// Reference model
	// ------------------------------

	function automatic sample_t spk_term_of(in_rec_t r);
		if (r.rst || !r.spk) begin
			return '0;
		end
		return sample_t'(1 << (SPK_SHIFT + int'(r.lvl)));
	endfunction

	// Two-slope curve on the magnitude with the sign put back afterwards
	function automatic sample_t curve(sample_t x, int knee, int base, int factor, int gain);
		int mag;
		int res;
		mag = (x < 0) ? -int'(x) : int'(x);
		if (mag < knee) begin
			res = mag * gain;
		end else begin
			res = (mag - knee) / factor + base;
		end
		if (x < 0) begin
			res = -res;
		end
		return sample_t'(res[15:0]);
	endfunction

	function automatic sample_t expected_out(int ch);
		sample_t sum;
		// Any clear in the last three stages leaves a zero at the output
		if (hist[0].rst || hist[1].rst || hist[2].rst) begin
			return '0;
		end
		sum = hist[2].smp[ch] + spk_term_of(hist[3]);
		case (hist[2].bsel)
			2'd0:    return sum;
			2'd1:    return curve(sum, KNEE_2X, BASE_2X, FACTOR_2X, GAIN_2X);
			default: return curve(sum, KNEE_4X, BASE_4X, FACTOR_4X, GAIN_4X);
		endcase
	endfunction

	// ------------------------------
	// Checks
	// ------------------------------

	task automatic check_sample(string name, sample_t got, sample_t exp);
		if (got !== exp) begin
			$display("Fail: %s cycle %0d got 0x%04h expected 0x%04h",
				name, cycle_no, got, exp);
			$display("Simulation failed");
			$fatal(1, "Audio output mismatch");
		end
	endtask

	task automatic check_outputs();
		for (int ch = 0; ch < N_CH; ch++) begin
			check_sample($sformatf("audio_out[%0d]", ch), audio_out[ch], expected_out(ch));
		end
	endtask

	// Store what the next rising edge will sample
	task automatic record_inputs();
		hist[3] = hist[2];
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0].rst  = cpu_reset;
		hist[0].smp  = sb_sample;
		hist[0].spk  = speaker_out;
		hist[0].lvl  = spk_level;
		hist[0].bsel = boost_sel;
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------

	task automatic run_cycle(sample_t [N_CH-1:0] smp, logic spk, spk_level_t lvl,
		logic [1:0] bsel);
		@(posedge clk_sys);
		sb_sample   <= smp;
		speaker_out <= spk;
		spk_level   <= lvl;
		boost_sel   <= bsel;
		cycle_no++;
		// Outputs are settled by the falling edge
		@(negedge clk_sys);
		check_outputs();
		record_inputs();
	endtask

	function automatic sample_t random_sample();
		return sample_t'($urandom);
	endfunction

	// Values on both sides of a knee plus full scale
	function automatic sample_t knee_sample(int knee);
		int pick;
		pick = int'($urandom_range(0, 7));
		case (pick)
			0:       return sample_t'(knee - 1);
			1:       return sample_t'(knee);
			2:       return sample_t'(knee + 1);
			3:       return sample_t'(-knee);
			4:       return sample_t'(-knee + 1);
			5:       return sample_t'(-knee - 1);
			6:       return sample_t'(16'h7fff);
			default: return sample_t'(16'h8000);
		endcase
	endfunction

	initial begin
		sample_t [N_CH-1:0] smp;
		logic               spk;
		spk_level_t         lvl;
		logic [1:0]         bsel;
		int                 hold;

		void'($urandom(SEED));
		sb_sample   = '0;
		speaker_out = 1'b0;
		spk_level   = '0;
		boost_sel   = 2'd0;
		cycle_no    = 0;
		hold        = 0;
		bsel        = 2'd0;
		for (int i = 0; i < 4; i++) begin
			hist[i]     = '0;
			hist[i].rst = 1'b1;
		end

		// Reset with live inputs and the cycles right after it
		for (int i = 0; i < N_RESET; i++) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				smp[ch] = random_sample();
			end
			spk  = 1'($urandom_range(0, 1));
			lvl  = spk_level_t'($urandom_range(0, 3));
			bsel = 2'($urandom_range(0, 3));
			run_cycle(smp, spk, lvl, bsel);
		end

		// Plain pass-through with independent channels
		for (int i = 0; i < N_PASS; i++) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				smp[ch] = random_sample();
			end
			run_cycle(smp, 1'b0, 2'd0, 2'd0);
		end

		// Speaker added on top of every channel
		for (int i = 0; i < N_SPK; i++) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				smp[ch] = random_sample();
			end
			spk = 1'($urandom_range(0, 1));
			lvl = spk_level_t'($urandom_range(0, 3));
			run_cycle(smp, spk, lvl, 2'd0);
		end

		// 2x curve
		for (int i = 0; i < N_2X; i++) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				smp[ch] = ($urandom_range(0, 2) == 0) ?
					knee_sample(KNEE_2X) : random_sample();
			end
			run_cycle(smp, 1'b0, 2'd0, 2'd1);
		end

		// 4x curve through both upper codes
		for (int i = 0; i < N_4X; i++) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				smp[ch] = ($urandom_range(0, 2) == 0) ?
					knee_sample(KNEE_4X) : random_sample();
			end
			run_cycle(smp, 1'b0, 2'd0, 2'($urandom_range(2, 3)));
		end

		// Boost changes in the middle of a continuous stream
		hold = 0;
		for (int i = 0; i < N_SWITCH; i++) begin
			if (hold == 0) begin
				bsel = 2'($urandom_range(0, 3));
				hold = int'($urandom_range(1, 4));
			end
			hold--;
			for (int ch = 0; ch < N_CH; ch++) begin
				smp[ch] = random_sample();
			end
			spk = 1'($urandom_range(0, 1));
			lvl = spk_level_t'($urandom_range(0, 3));
			run_cycle(smp, spk, lvl, bsel);
		end

		// Let the last samples leave the pipeline
		repeat (N_DRAIN) run_cycle('0, 1'b0, 2'd0, 2'd0);

		$display("Simulation completed successfully");
		$finish;
	end

	// ------------------------------
	// Watchdog
	// ------------------------------

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

//--- flist.f
hw/audio_pkg.sv
hw/speaker_mixer.sv
hw/sample_compressor.sv
hw/audio_out_stage.sv
hw/audio_output_path.sv
verif/tb_clock_gen.sv
verif/tb_audio_output_path.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the audio output path testbench with Verilator
set -e

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
BIN=sim_audio
LOG=sim.log

verilator --binary --timing --assert \
	-f flist.f \
	--top-module tb_audio_output_path \
	--Mdir "$OBJ_DIR" \
	-o "$BIN"

# A failing run stops the simulator with a nonzero status; the log is inspected below
"./$OBJ_DIR/$BIN" > "$LOG" 2>&1 || true

cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "Testbench reported a failure, see $LOG"
	exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
	echo "Testbench ended without a result, see $LOG"
	exit 1
fi

echo "Run passed"
